// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_mem_subsys --Mdir obj_dir -o tb_mem_subsys > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/tb_mem_subsys > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -q "Testbench failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

// File: sim/mem_patterns.txt
# name op(1=write) addr wdata exp_rdata exp_err resp_stall_cycles
# hex fields except the stall count, burst_N names run back to back
wr_a00 1 00 a5a50001 00000000 0 0
wr_a3f 1 3f 5a5a003f 00000000 0 0
rd_a00 0 00 00000000 a5a50001 0 0
rd_a3f 0 3f 00000000 5a5a003f 0 1
wr_a08 1 08 12345678 00000000 0 0
wr_a40_unmapped 1 40 deadbeef 00000000 1 0
wr_ac8_unmapped 1 c8 cafef00d 00000000 1 0
rd_a40_unmapped 0 40 00000000 00000000 1 2
rd_ac8_unmapped 0 c8 00000000 00000000 1 0
rd_a00_after 0 00 00000000 a5a50001 0 0
rd_a08_after 0 08 00000000 12345678 0 0
wr_a3f_again 1 3f 0f0f0f0f 00000000 0 3
rd_a3f_stall 0 3f 00000000 0f0f0f0f 0 7
rd_a08_stall 0 08 00000000 12345678 0 5
burst_0 1 10 11110000 00000000 0 30
burst_1 1 11 22220000 00000000 0 0
burst_2 0 10 00000000 11110000 0 2
burst_3 0 11 00000000 22220000 0 0
burst_4 0 c8 00000000 00000000 1 0
burst_5 0 3f 00000000 0f0f0f0f 0 0

// File: sim/mem_subsys_checker.sv
`timescale 1ns/1ns

module mem_subsys_checker
    import mem_subsys_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cmd_valid,
    input  logic         cmd_ready,
    input  logic [127:0] exp_name,
    input  mem_resp_t    exp_resp,
    input  logic         resp_valid,
    input  logic         resp_ready,
    input  mem_resp_t    resp,
    output int           pass_count,
    output int           fail_count,
    output int           pending,
    output logic         saw_full
);

    typedef struct packed {
        logic [127:0] name;
        mem_resp_t    resp;
    } expect_t;

    expect_t      expected [$];
    expect_t      head;
    expect_t      entry;
    logic         stalled;
    mem_resp_t    stalled_resp;
    logic [127:0] stalled_name;

    initial begin
        pass_count   = 0;
        fail_count   = 0;
        pending      = 0;
        saw_full     = 1'b0;
        stalled      = 1'b0;
        stalled_resp = '0;
        stalled_name = '0;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            // A held response must stay put until the host takes it
            if (stalled && (!resp_valid || resp != stalled_resp)) begin
                $display("response changed or dropped while stalled in test %0s", stalled_name);
                fail_count++;
            end
            if (resp_valid && resp_ready) begin
                if (expected.size() == 0) begin
                    $display("response arrived with no command outstanding");
                    fail_count++;
                end else begin
                    head = expected.pop_front();
                    if (resp == head.resp) begin
                        $display("[PASS] %0s rdata=%h err=%b", head.name, resp.rdata, resp.err);
                        pass_count++;
                    end else begin
                        $display("[FAIL] %0s expected rdata=%h err=%b actual rdata=%h err=%b",
                                 head.name, head.resp.rdata, head.resp.err, resp.rdata, resp.err);
                        fail_count++;
                    end
                end
            end
            // Expected values ride along with the command they belong to
            if (cmd_valid && cmd_ready) begin
                entry.name = exp_name;
                entry.resp = exp_resp;
                expected.push_back(entry);
            end
            if (cmd_valid && !cmd_ready) begin
                saw_full = 1'b1;
            end
            stalled      = resp_valid && !resp_ready;
            stalled_resp = resp;
            if (expected.size() > 0) begin
                stalled_name = expected[0].name;
            end
            pending = expected.size();
        end
    end

endmodule

// File: sim/tb_mem_subsys.sv
`timescale 1ns/1ns

module tb_mem_subsys
    import mem_subsys_pkg::*;
();

    localparam int MAX_TESTS  = 32;
    localparam int WAIT_LIMIT = 200;

    logic         clk;
    logic         rst_n;
    logic         cmd_valid;
    logic         cmd_ready;
    mem_cmd_t     cmd;
    logic         resp_valid;
    logic         resp_ready;
    mem_resp_t    resp;
    logic [127:0] exp_name;
    mem_resp_t    exp_resp;

    logic [127:0] pat_name  [MAX_TESTS];
    mem_cmd_t     pat_cmd   [MAX_TESTS];
    mem_resp_t    pat_resp  [MAX_TESTS];
    int           pat_stall [MAX_TESTS];
    int           num_tests;

    bit           hung;
    int           local_pass;
    int           local_fail;
    int           pass_count;
    int           fail_count;
    int           pending;
    logic         saw_full;

    mem_subsys_top mem_subsys_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    mem_subsys_checker mem_subsys_checker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .exp_name   (exp_name),
        .exp_resp   (exp_resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .pending    (pending),
        .saw_full   (saw_full)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic load_patterns();
        int           fd;
        int           got;
        int           fields;
        string        line;
        logic [127:0] name;
        logic [3:0]   op;
        logic [7:0]   addr;
        logic [31:0]  wdata;
        logic [31:0]  rdata;
        logic [3:0]   err;
        int           stall;
        num_tests = 0;
        fd = $fopen("sim/mem_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open pattern file sim/mem_patterns.txt");
            local_fail++;
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            got = $fgets(line, fd);
            if (got > 0 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %h %h %h %h %h %d",
                                 name, op, addr, wdata, rdata, err, stall);
                if (fields == 7) begin
                    pat_name[num_tests]       = name;
                    pat_cmd[num_tests].op     = mem_op_e'(op[0]);
                    pat_cmd[num_tests].addr   = addr;
                    pat_cmd[num_tests].wdata  = wdata;
                    pat_resp[num_tests].rdata = rdata;
                    pat_resp[num_tests].err   = err[0];
                    pat_stall[num_tests]      = stall;
                    num_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    // burst_N names are seven characters right-justified in the vector
    function automatic bit is_burst(input logic [127:0] name);
        return (name[127:56] == '0) && (name[55:16] == "burst");
    endfunction

    task automatic drive_commands();
        int gap;
        int waited;
        for (int i = 0; i < num_tests && !hung; i++) begin
            if (!is_burst(pat_name[i])) begin
                gap = $urandom_range(2, 0);
                repeat (gap) @(negedge clk);
            end
            cmd       = pat_cmd[i];
            exp_name  = pat_name[i];
            exp_resp  = pat_resp[i];
            cmd_valid = 1'b1;
            waited = 0;
            while (!cmd_ready && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!cmd_ready) begin
                $display("cmd_ready stuck low for test %0s", pat_name[i]);
                hung = 1'b1;
            end else begin
                // Transfer happens on the rising edge in between
                @(negedge clk);
            end
            cmd_valid = 1'b0;
        end
    endtask

    task automatic accept_responses();
        int waited;
        for (int i = 0; i < num_tests && !hung; i++) begin
            waited = 0;
            while (!resp_valid && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!resp_valid) begin
                $display("no response for test %0s", pat_name[i]);
                hung = 1'b1;
            end else begin
                repeat (pat_stall[i]) @(negedge clk);
                resp_ready = 1'b1;
                @(negedge clk);
                resp_ready = 1'b0;
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        resp_ready = 1'b0;
        exp_name   = '0;
        exp_resp   = '0;
        hung       = 1'b0;
        local_pass = 0;
        local_fail = 0;
        void'($urandom(32'he534));
        load_patterns();
        if (num_tests == 0) begin
            $display("no patterns loaded");
            local_fail++;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (cmd_ready === 1'b1 && resp_valid === 1'b0) begin
            $display("[PASS] reset_state cmd_ready=1 resp_valid=0");
            local_pass++;
        end else begin
            $display("[FAIL] reset_state expected ready=1 valid=0 actual ready=%b valid=%b",
                     cmd_ready, resp_valid);
            local_fail++;
        end
        fork
            drive_commands();
            accept_responses();
        join
        // Ready held high so a duplicate response would show up here
        resp_ready = 1'b1;
        repeat (8) @(negedge clk);
        resp_ready = 1'b0;
        if (!hung) begin
            if (saw_full) begin
                $display("[PASS] fifo_backpressure cmd_ready dropped");
                local_pass++;
            end else begin
                $display("cmd_ready never dropped during the command burst");
                local_fail++;
            end
            if (pending != 0) begin
                $display("%0d commands never got a response", pending);
                local_fail++;
            end
        end
        $display("Summary: %0d checks passed, %0d checks failed",
                 pass_count + local_pass, fail_count + local_fail);
        if (hung || fail_count != 0 || local_fail != 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

// File: verilog/cmd_fifo.sv
`timescale 1ns/1ns

module cmd_fifo
    import mem_subsys_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  mem_cmd_t in_cmd,

    output logic     out_valid,
    input  logic     out_ready,
    output mem_cmd_t out_cmd
);

    mem_cmd_t                  entries [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_CNT_WIDTH-1:0] count;
    logic                      push;
    logic                      pop;

    assign in_ready  = (count != FIFO_CNT_WIDTH'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_cmd   = entries[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Storage only, pointers decide what is valid
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_cmd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= FIFO_CNT_WIDTH'(FIFO_DEPTH)
    ) else $error("cmd_fifo count above depth");

    // Head entry must not move while the master holds off
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_cmd)
    ) else $error("cmd_fifo head changed while stalled");

endmodule

// File: verilog/ext_mem.sv
`timescale 1ns/1ns

module ext_mem
    import mem_subsys_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      req_vld,
    output logic                      req_rdy,

    input  logic                      wr_en,
    input  logic                      rd_en,

    input  logic [MEM_ADDR_WIDTH-1:0] addr,
    input  logic                      addr_hi_zero,
    input  logic [DATA_WIDTH-1:0]     wr_data,
    output logic [DATA_WIDTH-1:0]     rd_data,

    output logic                      ack_vld,
    input  logic                      ack_rdy
);

    logic [DATA_WIDTH-1:0]     mem [MEM_ENTRIES];

    // Registered copy of the accepted request
    logic                      acc_vld;
    logic                      acc_wr;
    logic                      acc_rd;
    logic                      acc_mapped;
    logic [MEM_ADDR_WIDTH-1:0] acc_addr;
    logic [DATA_WIDTH-1:0]     acc_wdata;

    // Access done on a mapped word, ack follows
    logic                      acc_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_rdy  <= 1'b0;
            acc_vld  <= 1'b0;
            acc_done <= 1'b0;
            ack_vld  <= 1'b0;
        end else begin
            // One-cycle ready pulse, never on two cycles in a row
            req_rdy  <= req_vld && !req_rdy;
            acc_vld  <= req_vld && req_rdy;
            acc_done <= acc_vld && acc_mapped;

            // Held until the master takes it
            if (ack_vld && ack_rdy) begin
                ack_vld <= 1'b0;
            end
            if (acc_done) begin
                ack_vld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_vld && req_rdy) begin
            acc_wr     <= wr_en;
            acc_rd     <= rd_en;
            acc_mapped <= addr_hi_zero;
            acc_addr   <= addr;
            acc_wdata  <= wr_data;
        end
    end

    // Unmapped requests fall through here without touching the array
    always_ff @(posedge clk) begin
        if (acc_vld && acc_mapped && acc_wr) begin
            mem[acc_addr] <= acc_wdata;
        end
    end

    // Read data stays put until the next read, covers a held ack
    always_ff @(posedge clk) begin
        if (acc_vld && acc_mapped && acc_rd) begin
            rd_data <= mem[acc_addr];
        end
    end

    a_one_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_vld |-> !(wr_en && rd_en)
    ) else $error("wr_en and rd_en both set on a request");

endmodule

// File: verilog/mem_subsys_pkg.sv
package mem_subsys_pkg;

    // Data path width on the host and native sides
    localparam int DATA_WIDTH = 32;

    // Host addresses cover 256 words; only the lower 64 are backed by memory
    localparam int HOST_ADDR_WIDTH = 8;
    localparam int MEM_ADDR_WIDTH = 6;
    localparam int MEM_ENTRIES = 64;

    // Command queue between host and master
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // Cycles the master waits for ack_vld before flagging an error
    localparam int ACK_TIMEOUT = 16;
    localparam int TMO_CNT_WIDTH = $clog2(ACK_TIMEOUT);

    // Host operation
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // Command as sent by the host, 41 bits
    typedef struct packed {
        mem_op_e                      op;
        logic [HOST_ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]        wdata;
    } mem_cmd_t;

    // One response per command, 33 bits
    // rdata is zero for writes and for failed accesses
    typedef struct packed {
        logic [DATA_WIDTH-1:0]        rdata;
        logic                         err;
    } mem_resp_t;

endpackage

// File: verilog/mem_subsys_top.sv
`timescale 1ns/1ns

module mem_subsys_top
    import mem_subsys_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  mem_cmd_t  cmd,

    output logic      resp_valid,
    input  logic      resp_ready,
    output mem_resp_t resp
);

    // Queue to master
    logic                      fifo_valid;
    logic                      fifo_ready;
    mem_cmd_t                  fifo_cmd;

    // Native interface
    logic                      req_vld;
    logic                      req_rdy;
    logic                      wr_en;
    logic                      rd_en;
    logic [MEM_ADDR_WIDTH-1:0] addr;
    logic                      addr_hi_zero;
    logic [DATA_WIDTH-1:0]     wr_data;
    logic [DATA_WIDTH-1:0]     rd_data;
    logic                      ack_vld;
    logic                      ack_rdy;

    cmd_fifo cmd_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .in_cmd    (cmd),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .out_cmd   (fifo_cmd)
    );

    reg_native_master reg_native_master_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (fifo_valid),
        .cmd_ready    (fifo_ready),
        .cmd          (fifo_cmd),
        .req_vld      (req_vld),
        .req_rdy      (req_rdy),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .addr         (addr),
        .addr_hi_zero (addr_hi_zero),
        .wr_data      (wr_data),
        .rd_data      (rd_data),
        .ack_vld      (ack_vld),
        .ack_rdy      (ack_rdy),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp         (resp)
    );

    ext_mem ext_mem_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_vld      (req_vld),
        .req_rdy      (req_rdy),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .addr         (addr),
        .addr_hi_zero (addr_hi_zero),
        .wr_data      (wr_data),
        .rd_data      (rd_data),
        .ack_vld      (ack_vld),
        .ack_rdy      (ack_rdy)
    );

endmodule

// File: verilog/reg_native_master.sv
`timescale 1ns/1ns

module reg_native_master
    import mem_subsys_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    input  mem_cmd_t                  cmd,

    output logic                      req_vld,
    input  logic                      req_rdy,
    output logic                      wr_en,
    output logic                      rd_en,
    output logic [MEM_ADDR_WIDTH-1:0] addr,
    output logic                      addr_hi_zero,
    output logic [DATA_WIDTH-1:0]     wr_data,
    input  logic [DATA_WIDTH-1:0]     rd_data,
    input  logic                      ack_vld,
    output logic                      ack_rdy,

    output logic                      resp_valid,
    input  logic                      resp_ready,
    output mem_resp_t                 resp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_RESP
    } state_e;

    state_e                   state;
    mem_cmd_t                 cmd_q;
    mem_resp_t                resp_q;
    logic [TMO_CNT_WIDTH-1:0] tmo_cnt;
    logic                     tmo_hit;

    assign tmo_hit = (tmo_cnt == TMO_CNT_WIDTH'(ACK_TIMEOUT - 1));

    // Handshake outputs follow the state directly
    assign cmd_ready  = (state == ST_IDLE);
    assign req_vld    = (state == ST_REQ);
    assign ack_rdy    = (state == ST_WAIT);
    assign resp_valid = (state == ST_RESP);

    // Enables only while a request is on the bus
    assign wr_en = req_vld && (cmd_q.op == OP_WRITE);
    assign rd_en = req_vld && (cmd_q.op == OP_READ);

    // Memory sees the low index bits, the rest only as a range flag
    assign addr         = cmd_q.addr[MEM_ADDR_WIDTH-1:0];
    assign addr_hi_zero = ~|cmd_q.addr[HOST_ADDR_WIDTH-1:MEM_ADDR_WIDTH];
    assign wr_data      = cmd_q.wdata;

    assign resp = resp_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            tmo_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (req_rdy) begin
                        state   <= ST_WAIT;
                        tmo_cnt <= '0;
                    end
                end
                ST_WAIT: begin
                    if (ack_vld || tmo_hit) begin
                        state <= ST_RESP;
                    end else begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end
                ST_RESP: begin
                    if (resp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command and response payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_valid) begin
            cmd_q <= cmd;
        end
        if (state == ST_WAIT) begin
            if (ack_vld) begin
                resp_q.rdata <= (cmd_q.op == OP_READ) ? rd_data : '0;
                resp_q.err   <= 1'b0;
            end else if (tmo_hit) begin
                // No ack from the memory, typically an unmapped address
                resp_q.rdata <= '0;
                resp_q.err   <= 1'b1;
            end
        end
    end

    a_req_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_vld && !req_rdy |=> req_vld
    ) else $error("req_vld dropped before req_rdy");

endmodule

// File: vlog.f
verilog/mem_subsys_pkg.sv
verilog/cmd_fifo.sv
verilog/reg_native_master.sv
verilog/ext_mem.sv
verilog/mem_subsys_top.sv
sim/mem_subsys_checker.sv
sim/tb_mem_subsys.sv
